/* logic/sdram_pkg.sv */
`default_nettype none

package sdram_pkg;

    // bank 0 word address, as on ba0_addr
    localparam int ba_aw = 22;

    // one bank word per dok
    localparam int ba_dw = 16;

    typedef logic [ba_dw-1:0] word_t;

    // two bank words, the first one read lands in hi
    typedef struct packed {
        word_t hi;
        word_t lo;
    } dword_t;

endpackage

`default_nettype wire

/* logic/game_pkg.sv */
`default_nettype none

package game_pkg;

    // CPU ROMs are addressed in 16-bit words
    localparam int main_aw = 18;
    localparam int sub_aw  = 18;

    // char tiles are addressed in 32-bit units
    localparam int char_aw = 13;

    // ROM regions inside bank 0, in bank words
    localparam logic [sdram_pkg::ba_aw-1:0] main_offset = 22'h00_0000;
    localparam logic [sdram_pkg::ba_aw-1:0] sub_offset  = 22'h04_0000;
    localparam logic [sdram_pkg::ba_aw-1:0] char_offset = 22'h08_0000;

endpackage

`default_nettype wire

/* logic/slot_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface slot_if;

    // request side
    logic                          req;
    logic [sdram_pkg::ba_aw-1:0]   addr;

    // return side, only active for the granted slot
    logic                          gnt;
    logic                          dst;
    logic                          dok;
    logic                          rdy;
    sdram_pkg::word_t              data;

    modport slot (
        output req, addr,
        input  gnt, dst, dok, rdy, data
    );

    modport arbiter (
        input  req, addr,
        output gnt, dst, dok, rdy, data
    );

endinterface

`default_nettype wire

/* logic/jtoutrun_rom_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module jtoutrun_rom_slot #(
    parameter logic [sdram_pkg::ba_aw-1:0] OFFSET = '0,
    parameter int                          AW     = 18,
    parameter type                         payload_t = sdram_pkg::word_t
)(
    input  logic            clk,
    input  logic            arst_n,

    input  logic            cs,
    input  logic [AW-1:0]   addr,
    output payload_t        data,
    output logic            ok,

    slot_if.slot            bus
);

    localparam int PW    = $bits(payload_t);
    localparam int WORDS = PW / sdram_pkg::ba_dw;
    // client address to bank word address
    localparam int SHIFT = $clog2(WORDS);

    logic            valid;
    logic            inflight;
    logic [AW-1:0]   tag;
    logic [AW-1:0]   lat_addr;
    logic [PW-1:0]   asm;
    logic [PW-1:0]   asm_nx;
    logic            miss;
    logic            take;

    // hit is purely combinational against the live address
    assign ok   = cs & valid & (tag == addr);
    assign miss = cs & ~ok & ~bus.req;

    // return strobes count once the bank has taken our access
    assign take = inflight | bus.gnt;

    // words shift in from the bottom, so the first word ends up on top
    always_comb begin
        if (take && bus.dok) begin
            if (bus.dst) begin
                asm_nx = PW'(bus.data);
            end else begin
                asm_nx = PW'({asm, bus.data});
            end
        end else if (take && bus.dst) begin
            // fresh burst
            asm_nx = '0;
        end else begin
            asm_nx = asm;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid    <= 1'b0;
            inflight <= 1'b0;
            bus.req  <= 1'b0;
        end else begin
            if (miss) begin
                bus.req <= 1'b1;
            end
            if (bus.gnt) begin
                inflight <= 1'b1;
            end
            if (take && bus.rdy) begin
                bus.req  <= 1'b0;
                inflight <= 1'b0;
                valid    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        asm <= asm_nx;
        if (miss) begin
            lat_addr <= addr;
            bus.addr <= OFFSET + (sdram_pkg::ba_aw'(addr) << SHIFT);
        end
        // the last word arrives together with rdy
        if (take && bus.rdy) begin
            tag  <= lat_addr;
            data <= payload_t'(asm_nx);
        end
    end

endmodule

`default_nettype wire

/* logic/jtoutrun_bank_arb.sv */
`timescale 1ns/1ps
`default_nettype none

module jtoutrun_bank_arb #(
    parameter int CLIENTS = 3
)(
    input  logic            clk,
    input  logic            arst_n,

    slot_if.arbiter         slots [CLIENTS],

    output logic [21:0]     ba0_addr,
    output logic            ba_rd,
    input  logic            ba_ack,
    input  logic            ba_dst,
    input  logic            ba_dok,
    input  logic            ba_rdy,
    input  logic [15:0]     data_read
);

    localparam int IW = CLIENTS > 1 ? $clog2(CLIENTS) : 1;

    logic [CLIENTS-1:0]  req;
    logic [21:0]         req_addr [CLIENTS];
    logic [IW-1:0]       sel;
    logic [IW-1:0]       nxt;
    logic                busy;

    // interface arrays only take constant indexes
    for (genvar i = 0; i < CLIENTS; i++) begin : g_slot
        logic mine;

        assign req[i]      = slots[i].req;
        assign req_addr[i] = slots[i].addr;

        assign mine = busy & (sel == IW'(i));

        assign slots[i].gnt  = mine & ba_rd & ba_ack;
        assign slots[i].dst  = mine & ba_dst;
        assign slots[i].dok  = mine & ba_dok;
        assign slots[i].rdy  = mine & ba_rdy;
        assign slots[i].data = mine ? data_read : '0;
    end

    // next requester after the last one served
    always_comb begin
        int  idx;
        logic found;

        nxt   = sel;
        found = 1'b0;
        for (int k = 1; k <= CLIENTS; k++) begin
            idx = (int'(sel) + k) % CLIENTS;
            if (!found && req[idx]) begin
                found = 1'b1;
                nxt   = IW'(idx);
            end
        end
    end

    // busy low means idle, ba_rd high while waiting for ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            ba_rd <= 1'b0;
            sel   <= IW'(CLIENTS - 1);
        end else begin
            if (!busy) begin
                if (|req) begin
                    busy  <= 1'b1;
                    ba_rd <= 1'b1;
                    sel   <= nxt;
                end
            end else begin
                if (ba_rd && ba_ack) begin
                    ba_rd <= 1'b0;
                end
                // the cycle after rdy stays idle
                if (ba_rdy) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && |req) begin
            ba0_addr <= req_addr[nxt];
        end
    end

endmodule

`default_nettype wire

/* logic/jtoutrun_sdram.sv */
`timescale 1ns/1ps
`default_nettype none

module jtoutrun_sdram #(
    parameter int                          MAIN_AW     = game_pkg::main_aw,
    parameter int                          SUB_AW      = game_pkg::sub_aw,
    parameter int                          CHAR_AW     = game_pkg::char_aw,
    parameter logic [sdram_pkg::ba_aw-1:0] MAIN_OFFSET = game_pkg::main_offset,
    parameter logic [sdram_pkg::ba_aw-1:0] SUB_OFFSET  = game_pkg::sub_offset,
    parameter logic [sdram_pkg::ba_aw-1:0] CHAR_OFFSET = game_pkg::char_offset
)(
    input  logic                          clk,
    input  logic                          arst_n,

    // main CPU ROM
    input  logic                          main_cs,
    input  logic [MAIN_AW-1:0]            main_addr,
    output logic [sdram_pkg::ba_dw-1:0]   main_data,
    output logic                          main_ok,

    // sub CPU ROM
    input  logic                          sub_cs,
    input  logic [SUB_AW-1:0]             sub_addr,
    output logic [sdram_pkg::ba_dw-1:0]   sub_data,
    output logic                          sub_ok,

    // char tiles, 32 bits per access
    input  logic                          char_cs,
    input  logic [CHAR_AW-1:0]            char_addr,
    output logic [2*sdram_pkg::ba_dw-1:0] char_data,
    output logic                          char_ok,

    // bank 0
    output logic [sdram_pkg::ba_aw-1:0]   ba0_addr,
    output logic                          ba_rd,
    input  logic                          ba_ack,
    input  logic                          ba_dst,
    input  logic                          ba_dok,
    input  logic                          ba_rdy,
    input  logic [sdram_pkg::ba_dw-1:0]   data_read
);

    // 0 main, 1 sub, 2 char
    slot_if u_bus [3] ();

    jtoutrun_rom_slot #(
        .OFFSET     ( MAIN_OFFSET        ),
        .AW         ( MAIN_AW            ),
        .payload_t  ( sdram_pkg::word_t  )
    ) u_main_slot (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cs         ( main_cs    ),
        .addr       ( main_addr  ),
        .data       ( main_data  ),
        .ok         ( main_ok    ),
        .bus        ( u_bus[0]   )
    );

    jtoutrun_rom_slot #(
        .OFFSET     ( SUB_OFFSET         ),
        .AW         ( SUB_AW             ),
        .payload_t  ( sdram_pkg::word_t  )
    ) u_sub_slot (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cs         ( sub_cs     ),
        .addr       ( sub_addr   ),
        .data       ( sub_data   ),
        .ok         ( sub_ok     ),
        .bus        ( u_bus[1]   )
    );

    jtoutrun_rom_slot #(
        .OFFSET     ( CHAR_OFFSET        ),
        .AW         ( CHAR_AW            ),
        .payload_t  ( sdram_pkg::dword_t )
    ) u_char_slot (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cs         ( char_cs    ),
        .addr       ( char_addr  ),
        .data       ( char_data  ),
        .ok         ( char_ok    ),
        .bus        ( u_bus[2]   )
    );

    jtoutrun_bank_arb #(
        .CLIENTS    ( 3          )
    ) u_arb (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .slots      ( u_bus      ),
        .ba0_addr   ( ba0_addr   ),
        .ba_rd      ( ba_rd      ),
        .ba_ack     ( ba_ack     ),
        .ba_dst     ( ba_dst     ),
        .ba_dok     ( ba_dok     ),
        .ba_rdy     ( ba_rdy     ),
        .data_read  ( data_read  )
    );

endmodule

`default_nettype wire

/* tests/sdram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_model #(
    // accesses at or above this address return a pair of words
    parameter logic [21:0] PAIR_BASE = 22'h08_0000,
    parameter int          DATA_LAT  = 4
)(
    input  logic         clk,
    input  logic         arst_n,

    input  logic [21:0]  ba0_addr,
    input  logic         ba_rd,
    output logic         ba_ack,
    output logic         ba_dst,
    output logic         ba_dok,
    output logic         ba_rdy,
    output logic [15:0]  data_read
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        LATENCY,
        BURST
    } state_t;

    state_t        st     = IDLE;
    logic [2:0]    cnt    = '0;
    logic [21:0]   addr_q = '0;
    logic          pair   = 1'b0;
    logic          ack_q  = 1'b0;
    logic          dst_q  = 1'b0;
    logic          dok_q  = 1'b0;
    logic          rdy_q  = 1'b0;
    logic [15:0]   dout_q = '0;

    assign ba_ack    = ack_q;
    assign ba_dst    = dst_q;
    assign ba_dok    = dok_q;
    assign ba_rdy    = rdy_q;
    assign data_read = dout_q;

    // memory contents are a fixed function of the address
    function automatic logic [15:0] mem_word(input logic [21:0] a);
        return a[15:0] ^ 16'hA5C3;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st     <= IDLE;
            cnt    <= '0;
            addr_q <= '0;
            pair   <= 1'b0;
            ack_q  <= 1'b0;
            dst_q  <= 1'b0;
            dok_q  <= 1'b0;
            rdy_q  <= 1'b0;
            dout_q <= '0;
        end else begin
            // strobes are single cycle pulses
            ack_q <= 1'b0;
            dst_q <= 1'b0;
            dok_q <= 1'b0;
            rdy_q <= 1'b0;
            case (st)
                IDLE: begin
                    if (ba_rd) begin
                        cnt <= 3'($urandom % 4);
                        st  <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (cnt == '0) begin
                        ack_q  <= 1'b1;
                        addr_q <= ba0_addr;
                        pair   <= (ba0_addr >= PAIR_BASE);
                        cnt    <= 3'(DATA_LAT - 1);
                        st     <= LATENCY;
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
                LATENCY: begin
                    if (cnt == '0) begin
                        dst_q  <= 1'b1;
                        dok_q  <= 1'b1;
                        dout_q <= mem_word(addr_q);
                        rdy_q  <= !pair;
                        st     <= pair ? BURST : IDLE;
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
                default: begin
                    // second word of a pair
                    dok_q  <= 1'b1;
                    rdy_q  <= 1'b1;
                    dout_q <= mem_word(addr_q + 22'd1);
                    st     <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tests/tb_jtoutrun_sdram.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_jtoutrun_sdram;

    localparam logic [21:0] MAIN_BASE  = 22'h00_0000;
    localparam logic [21:0] SUB_BASE   = 22'h04_0000;
    localparam logic [21:0] CHAR_BASE  = 22'h08_0000;
    localparam int          TIMEOUT    = 200;
    localparam int          HIT_WINDOW = 12;
    localparam int          ROWS       = 10;

    // mask bit 0 main, bit 1 sub, bit 2 char
    typedef struct packed {
        logic [2:0]  mask;
        logic [17:0] main_a;
        logic [17:0] sub_a;
        logic [12:0] char_a;
        logic        hit;
    } row_t;

    logic          clk = 1'b0;
    logic          arst_n;
    logic          main_cs;
    logic [17:0]   main_addr;
    logic [15:0]   main_data;
    logic          main_ok;
    logic          sub_cs;
    logic [17:0]   sub_addr;
    logic [15:0]   sub_data;
    logic          sub_ok;
    logic          char_cs;
    logic [12:0]   char_addr;
    logic [31:0]   char_data;
    logic          char_ok;
    logic [21:0]   ba0_addr;
    logic          ba_rd;
    logic          ba_ack;
    logic          ba_dst;
    logic          ba_dok;
    logic          ba_rdy;
    logic [15:0]   data_read;

    row_t          rows [ROWS];

    always #2 clk = ~clk;

    jtoutrun_sdram u_dut (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .main_cs   ( main_cs   ),
        .main_addr ( main_addr ),
        .main_data ( main_data ),
        .main_ok   ( main_ok   ),
        .sub_cs    ( sub_cs    ),
        .sub_addr  ( sub_addr  ),
        .sub_data  ( sub_data  ),
        .sub_ok    ( sub_ok    ),
        .char_cs   ( char_cs   ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .char_ok   ( char_ok   ),
        .ba0_addr  ( ba0_addr  ),
        .ba_rd     ( ba_rd     ),
        .ba_ack    ( ba_ack    ),
        .ba_dst    ( ba_dst    ),
        .ba_dok    ( ba_dok    ),
        .ba_rdy    ( ba_rdy    ),
        .data_read ( data_read )
    );

    sdram_model #(
        .PAIR_BASE ( CHAR_BASE )
    ) u_bank (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .ba0_addr  ( ba0_addr  ),
        .ba_rd     ( ba_rd     ),
        .ba_ack    ( ba_ack    ),
        .ba_dst    ( ba_dst    ),
        .ba_dok    ( ba_dok    ),
        .ba_rdy    ( ba_rdy    ),
        .data_read ( data_read )
    );

    function automatic logic [15:0] bank_word(input logic [21:0] a);
        return a[15:0] ^ 16'hA5C3;
    endfunction

    // char data is two words, the lower address on top
    function automatic logic [31:0] char_word(input logic [12:0] a);
        logic [21:0] base;
        base = CHAR_BASE + (22'(a) << 1);
        return {bank_word(base), bank_word(base + 22'd1)};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_data(input logic [2:0] which, input row_t r);
        if (which[0]) check("main_data", 32'(main_data), 32'(bank_word(MAIN_BASE + 22'(r.main_a))));
        if (which[1]) check("sub_data", 32'(sub_data), 32'(bank_word(SUB_BASE + 22'(r.sub_a))));
        if (which[2]) check("char_data", char_data, char_word(r.char_a));
    endtask

    // sampled on the falling edge, away from the driving edge
    task automatic wait_all_ok(input row_t r);
        logic [2:0]  done;
        logic [2:0]  pending;
        logic [21:0] want [3];
        logic        found;
        int          cycles;
        string       who;
        done    = ~r.mask;
        pending = r.mask;
        cycles  = 0;
        // bank word address each client should read
        want[0] = MAIN_BASE + 22'(r.main_a);
        want[1] = SUB_BASE + 22'(r.sub_a);
        want[2] = CHAR_BASE + (22'(r.char_a) << 1);
        while (done != 3'b111) begin
            // every accepted bank read belongs to one waiting client
            if (ba_rd && ba_ack) begin
                found = 1'b0;
                for (int k = 0; k < 3; k++) begin
                    if (!found && pending[k] && ba0_addr == want[k]) begin
                        pending[k] = 1'b0;
                        found      = 1'b1;
                    end
                end
                if (!found) begin
                    abort_run($sformatf("bank read at %h matches no waiting client at %0d ns",
                                        ba0_addr, $time));
                end
            end
            if (!done[0] && main_ok) begin
                check_data(3'b001, r);
                done[0] = 1'b1;
            end
            if (!done[1] && sub_ok) begin
                check_data(3'b010, r);
                done[1] = 1'b1;
            end
            if (!done[2] && char_ok) begin
                check_data(3'b100, r);
                done[2] = 1'b1;
            end
            if (done != 3'b111) begin
                cycles++;
                if (cycles > TIMEOUT) begin
                    if (!done[0])
                        who = "main";
                    else if (!done[1])
                        who = "sub";
                    else
                        who = "char";
                    abort_run($sformatf("timeout: the %s client never got ok within %0d cycles",
                                        who, TIMEOUT));
                end
                @(negedge clk);
            end
        end
    endtask

    // a hit must answer at once and leave the bank alone
    task automatic watch_hit(input row_t r);
        repeat (HIT_WINDOW) begin
            if (r.mask[0]) check("main_ok", 32'(main_ok), 32'd1);
            if (r.mask[1]) check("sub_ok", 32'(sub_ok), 32'd1);
            if (r.mask[2]) check("char_ok", 32'(char_ok), 32'd1);
            check("ba_rd", 32'(ba_rd), 32'd0);
            check_data(r.mask, r);
            @(negedge clk);
        end
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk);
        main_cs   <= r.mask[0];
        main_addr <= r.main_a;
        sub_cs    <= r.mask[1];
        sub_addr  <= r.sub_a;
        char_cs   <= r.mask[2];
        char_addr <= r.char_a;
        @(negedge clk);
        if (r.hit) begin
            watch_hit(r);
        end else begin
            // a new address drops ok in the same cycle
            if (r.mask[0]) check("main_ok", 32'(main_ok), 32'd0);
            if (r.mask[1]) check("sub_ok", 32'(sub_ok), 32'd0);
            if (r.mask[2]) check("char_ok", 32'(char_ok), 32'd0);
            wait_all_ok(r);
        end
    endtask

    initial begin
        void'($urandom(55));
        arst_n    = 1'b0;
        main_cs   = 1'b0;
        main_addr = '0;
        sub_cs    = 1'b0;
        sub_addr  = '0;
        char_cs   = 1'b0;
        char_addr = '0;

        // mask, main, sub, char, hit
        rows[0] = '{3'b001, 18'h00123, 18'h00000, 13'h0000, 1'b0};
        rows[1] = '{3'b010, 18'h00123, 18'h01234, 13'h0000, 1'b0};
        rows[2] = '{3'b100, 18'h00123, 18'h01234, 13'h0456, 1'b0};
        rows[3] = '{3'b111, 18'h2abcd, 18'h3f00f, 13'h1fff, 1'b0};
        rows[4] = '{3'b111, 18'h2abcd, 18'h3f00f, 13'h1fff, 1'b1};
        rows[5] = '{3'b001, 18'h2abcd, 18'h3f00f, 13'h1fff, 1'b1};
        // main moves away from a hit
        rows[6] = '{3'b111, 18'h00124, 18'h3f010, 13'h0457, 1'b0};
        rows[7] = '{3'b111, 18'h3ffff, 18'h00000, 13'h1000, 1'b0};
        rows[8] = '{3'b101, 18'h3ffff, 18'h00000, 13'h1000, 1'b1};
        rows[9] = '{3'b010, 18'h3ffff, 18'h00000, 13'h1000, 1'b1};

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        // quiet bus before any client asks
        repeat (4) begin
            @(negedge clk);
            check("ba_rd", 32'(ba_rd), 32'd0);
            check("main_ok", 32'(main_ok), 32'd0);
            check("sub_ok", 32'(sub_ok), 32'd0);
            check("char_ok", 32'(char_ok), 32'd0);
        end

        for (int i = 0; i < ROWS; i++) begin
            apply_row(rows[i]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/sdram_pkg.sv
logic/game_pkg.sv
logic/slot_if.sv
logic/jtoutrun_rom_slot.sv
logic/jtoutrun_bank_arb.sv
logic/jtoutrun_sdram.sv
tests/sdram_model.sv
tests/tb_jtoutrun_sdram.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -j 0 \
    --top-module tb_jtoutrun_sdram -f filelist.f \
    || { echo "build failed"; exit 1; }

./obj_dir/Vtb_jtoutrun_sdram 2>&1 | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
